// ==== files.f ====
+incdir+bench
common/ising_pkg.sv
energy_monitor/weight_fetch.sv
energy_monitor/energy_monitor.sv
flip_manager/flip_manager.sv
hdl/digital_macro.sv
bench/tb_digital_macro.sv

// ==== Bender.yml ====
package:
  name: digital_macro

sources:
  # shared package
  - common/ising_pkg.sv
  # RTL
  - energy_monitor/weight_fetch.sv
  - energy_monitor/energy_monitor.sv
  - flip_manager/flip_manager.sv
  - hdl/digital_macro.sv
  # testbench
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_digital_macro.sv

// ==== bench/ising_model.svh ====
`ifndef ISING_MODEL_SVH
`define ISING_MODEL_SVH

integer seed = 32'h7eb88c00;

// problem data J[i][j] and h[i] as plain integers
int    j_mat [NUM_SPIN][NUM_SPIN];
int    h_vec [NUM_SPIN];
int    h_scale;
spin_t flip_mem [2**FLIP_ADDR_W];

// expected history with entry 0 the newest
int    exp_energy [SPIN_DEPTH];
spin_t exp_spin [SPIN_DEPTH];
int    exp_pulses;

function automatic int rand_entry();
    logic signed [BITJ-1:0] v;
    v = BITJ'($random(seed));
    return v;
endfunction

task automatic randomize_problem();
    logic [SCALING_BIT-1:0] s;
    for (int i = 0; i < NUM_SPIN; i++) begin
        for (int j = 0; j < NUM_SPIN; j++) begin
            j_mat[i][j] = rand_entry();
        end
        h_vec[i] = rand_entry();
    end
    s = SCALING_BIT'($random(seed));
    h_scale = s;
endtask

task automatic randomize_masks(input int entries);
    for (int a = 0; a < entries; a++) begin
        flip_mem[a] = spin_t'($random(seed));
    end
endtask

// E = sum_i s_i * (sum_j J_ij*s_j + scale*h_i) with the diagonal included
function automatic int model_energy(input spin_t s);
    int total;
    int local_f;
    total = 0;
    for (int i = 0; i < NUM_SPIN; i++) begin
        local_f = h_scale * h_vec[i];
        for (int j = 0; j < NUM_SPIN; j++) begin
            local_f += s[j] ? j_mat[i][j] : -j_mat[i][j];
        end
        total += s[i] ? local_f : -local_f;
    end
    return total;
endfunction

// walks the candidates of one run and shifts the expected history
task automatic replay_run(input spin_t init, input int entries, input logic cmp_on);
    spin_t cur;
    spin_t cand;
    int    e;
    exp_pulses = 0;
    cur = init;
    for (int a = -1; a < entries; a++) begin
        cand = (a < 0) ? init : (cur ^ flip_mem[a]);
        e = model_energy(cand);
        if (a < 0 || !cmp_on || e < exp_energy[0]) begin
            exp_energy[1] = exp_energy[0];
            exp_spin[1] = exp_spin[0];
            exp_energy[0] = e;
            exp_spin[0] = cand;
            cur = cand;
            exp_pulses++;
        end
    end
endtask

task automatic check_value(input string test_name, input logic signed [63:0] expected,
                           input logic signed [63:0] actual);
    if (expected !== actual) begin
        $display("ERROR %s: expected %0d, actual %0d", test_name, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1, "value mismatch in %s", test_name);
    end
endtask

`endif

// ==== bench/tb_digital_macro.sv ====
module tb_digital_macro import ising_pkg::*; ();
    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY = 2;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS = 5;
    localparam int MAX_ENTRIES = 12;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (MAX_ENTRIES + 1) * 40;

    logic                   clk;
    logic                   rst;
    logic                   config_valid;
    spin_t                  config_spin;
    logic                   cmpt_en;
    logic                   en_comparison;
    logic                   cmpt_idle;
    logic                   weight_ren;
    logic [J_ADDR_W-1:0]    weight_raddr;
    j_beat_t                weight_data;
    hbias_t                 hbias;
    logic [SCALING_BIT-1:0] hscaling;
    logic                   flip_ren;
    logic [FLIP_ADDR_W-1:0] flip_raddr;
    logic [FLIP_ADDR_W-1:0] icon_last;
    spin_t                  flip_rdata;
    logic                   energy_update;
    logic                   spin_update;
    energy_hist_t           energy_fifo;
    spin_hist_t             spin_fifo;

    j_beat_t                j_mem [NUM_READS];
    int                     energy_pulses = 0;
    int                     spin_pulses = 0;
    int                     weight_reads = 0;
    int                     exp_waddr = 0;
    int                     exp_faddr = 0;

    `include "ising_model.svh"

    digital_macro uut (
        .clk_i                      (clk),
        .rst_i                      (rst),
        .config_valid_fm_i          (config_valid),
        .config_spin_initial_i      (config_spin),
        .cmpt_en_i                  (cmpt_en),
        .en_comparison_i            (en_comparison),
        .cmpt_idle_o                (cmpt_idle),
        .dgt_weight_ren_o           (weight_ren),
        .dgt_weight_raddr_o         (weight_raddr),
        .dgt_weight_i               (weight_data),
        .dgt_hbias_i                (hbias),
        .dgt_hscaling_i             (hscaling),
        .flip_ren_o                 (flip_ren),
        .flip_raddr_o               (flip_raddr),
        .icon_last_raddr_plus_one_i (icon_last),
        .flip_rdata_i               (flip_rdata),
        .energy_fifo_update_o       (energy_update),
        .spin_fifo_update_o         (spin_update),
        .energy_fifo_o              (energy_fifo),
        .spin_fifo_o                (spin_fifo)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // both memories answer one cycle after the strobe
    initial begin
        logic                   j_ren_seen;
        logic [J_ADDR_W-1:0]    j_addr_seen;
        logic                   f_ren_seen;
        logic [FLIP_ADDR_W-1:0] f_addr_seen;
        forever begin
            @(negedge clk);
            j_ren_seen = weight_ren;
            j_addr_seen = weight_raddr;
            f_ren_seen = flip_ren;
            f_addr_seen = flip_raddr;
            @(posedge clk);
            #DRIVE_DLY;
            if (j_ren_seen) begin
                weight_data = j_mem[j_addr_seen];
            end
            if (f_ren_seen) begin
                flip_rdata = flip_mem[f_addr_seen];
            end
        end
    end

    // update pulses and memory read order
    always @(negedge clk) begin
        if (energy_update) begin
            energy_pulses++;
        end
        if (spin_update) begin
            spin_pulses++;
        end
        if (rst) begin
            exp_waddr = 0;
        end else if (weight_ren) begin
            check_value("weight_order address", exp_waddr, weight_raddr);
            exp_waddr = (exp_waddr + 1) % NUM_READS;
            weight_reads++;
        end
        // flip entries are read in order once per run
        if (cmpt_idle) begin
            exp_faddr = 0;
        end else if (flip_ren) begin
            check_value("flip read address", exp_faddr, flip_raddr);
            exp_faddr++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    task automatic pack_problem();
        for (int a = 0; a < NUM_READS; a++) begin
            for (int k = 0; k < PARALLELISM; k++) begin
                for (int j = 0; j < NUM_SPIN; j++) begin
                    j_mem[a][k][j] = BITJ'(j_mat[a * PARALLELISM + k][j]);
                end
            end
        end
        for (int i = 0; i < NUM_SPIN; i++) begin
            hbias[i] = BITJ'(h_vec[i]);
        end
        hscaling = SCALING_BIT'(h_scale);
    endtask

    // new J, h and scaling are loaded while reset is held
    task automatic reset_with_new_problem();
        @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b1;
        randomize_problem();
        pack_problem();
        for (int i = 0; i < SPIN_DEPTH; i++) begin
            exp_energy[i] = 0;
            exp_spin[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
    endtask

    task automatic run_and_wait(input spin_t init, input int entries, input logic cmp_on);
        @(posedge clk);
        #DRIVE_DLY;
        config_valid = 1'b1;
        config_spin = init;
        icon_last = FLIP_ADDR_W'(entries);
        en_comparison = cmp_on;
        energy_pulses = 0;
        spin_pulses = 0;
        @(posedge clk);
        #DRIVE_DLY;
        config_valid = 1'b0;
        cmpt_en = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        cmpt_en = 1'b0;
        while (!cmpt_idle) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        // last update pulse is counted in this cycle
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_history(input string test_name);
        for (int i = 0; i < SPIN_DEPTH; i++) begin
            check_value({test_name, " energy"}, exp_energy[i], energy_fifo[i]);
            check_value({test_name, " spin"}, exp_spin[i], spin_fifo[i]);
        end
        check_value({test_name, " energy pulses"}, exp_pulses, energy_pulses);
        check_value({test_name, " spin pulses"}, exp_pulses, spin_pulses);
    endtask

    task automatic reset_state_test();
        check_value("reset_state idle", 1, cmpt_idle);
        check_value("reset_state energy update", 0, energy_update);
        check_value("reset_state spin update", 0, spin_update);
        for (int i = 0; i < SPIN_DEPTH; i++) begin
            check_value("reset_state energy fifo", 0, energy_fifo[i]);
            check_value("reset_state spin fifo", 0, spin_fifo[i]);
        end
    endtask

    task automatic single_eval_test();
        spin_t spins [3];
        spins[0] = '1;
        spins[1] = {(NUM_SPIN / 2){2'b10}};
        spins[2] = spin_t'($random(seed));
        for (int t = 0; t < 3; t++) begin
            reset_with_new_problem();
            run_and_wait(spins[t], 0, 1'b1);
            check_value("single_eval spin", spins[t], spin_fifo[0]);
            check_value("single_eval energy", model_energy(spins[t]), energy_fifo[0]);
            check_value("single_eval pulses", 1, energy_pulses);
        end
    endtask

    task automatic compare_on_test();
        spin_t init;
        reset_with_new_problem();
        randomize_masks(MAX_ENTRIES);
        init = spin_t'($random(seed));
        run_and_wait(init, MAX_ENTRIES, 1'b1);
        replay_run(init, MAX_ENTRIES, 1'b1);
        check_history("compare_on");
    endtask

    task automatic compare_off_test();
        spin_t init;
        spin_t prev;
        int    entries;
        entries = 8;
        reset_with_new_problem();
        randomize_masks(entries);
        init = spin_t'($random(seed));
        run_and_wait(init, entries, 1'b0);
        prev = init;
        for (int a = 0; a < entries - 1; a++) begin
            prev = prev ^ flip_mem[a];
        end
        check_value("compare_off pulses", entries + 1, energy_pulses);
        check_value("compare_off spin pulses", entries + 1, spin_pulses);
        check_value("compare_off prev spin", prev, spin_fifo[1]);
        check_value("compare_off prev energy", model_energy(prev), energy_fifo[1]);
        check_value("compare_off last spin", prev ^ flip_mem[entries - 1], spin_fifo[0]);
    endtask

    task automatic weight_order_test();
        spin_t init;
        int    reads_before;
        reset_with_new_problem();
        randomize_masks(4);
        reads_before = weight_reads;
        for (int r = 0; r < 2; r++) begin
            init = spin_t'($random(seed));
            run_and_wait(init, 4, 1'b1);
            replay_run(init, 4, 1'b1);
            check_history("weight_order");
        end
        // every candidate consumes one full matrix
        check_value("weight_order enough reads", 1,
                    (weight_reads - reads_before) >= 2 * 5 * NUM_READS);
    endtask

    initial begin
        rst = 1'b1;
        config_valid = 1'b0;
        config_spin = '0;
        cmpt_en = 1'b0;
        en_comparison = 1'b0;
        weight_data = '0;
        hbias = '0;
        hscaling = '0;
        icon_last = '0;
        flip_rdata = '0;
        reset_with_new_problem();
        reset_state_test();
        single_eval_test();
        compare_on_test();
        compare_off_test();
        weight_order_test();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== hdl/digital_macro.sv ====
module digital_macro import ising_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // configuration
    input  logic                   config_valid_fm_i,
    input  spin_t                  config_spin_initial_i,
    // run control
    input  logic                   cmpt_en_i,
    input  logic                   en_comparison_i,
    output logic                   cmpt_idle_o,
    // J memory
    output logic                   dgt_weight_ren_o,
    output logic [J_ADDR_W-1:0]    dgt_weight_raddr_o,
    input  j_beat_t                dgt_weight_i,
    input  hbias_t                 dgt_hbias_i,
    input  logic [SCALING_BIT-1:0] dgt_hscaling_i,
    // flip-icon memory
    output logic                   flip_ren_o,
    output logic [FLIP_ADDR_W-1:0] flip_raddr_o,
    input  logic [FLIP_ADDR_W-1:0] icon_last_raddr_plus_one_i,
    input  spin_t                  flip_rdata_i,
    // accepted history
    output logic                   energy_fifo_update_o,
    output logic                   spin_fifo_update_o,
    output energy_hist_t           energy_fifo_o,
    output spin_hist_t             spin_fifo_o
);
    logic        beat_valid;
    logic        beat_ready;
    j_beat_t     beat;

    logic        spin_valid;
    logic        spin_ready;
    spin_req_t   spin_req;

    logic        energy_valid;
    logic        energy_ready;
    energy_rsp_t energy_rsp;

    weight_fetch u_weight_fetch (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem_ren_o    (dgt_weight_ren_o),
        .mem_raddr_o  (dgt_weight_raddr_o),
        .mem_rdata_i  (dgt_weight_i),
        .beat_valid_o (beat_valid),
        .beat_ready_i (beat_ready),
        .beat_o       (beat)
    );

    energy_monitor u_energy_monitor (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .spin_valid_i   (spin_valid),
        .spin_ready_o   (spin_ready),
        .spin_i         (spin_req),
        .beat_valid_i   (beat_valid),
        .beat_ready_o   (beat_ready),
        .beat_i         (beat),
        .hbias_i        (dgt_hbias_i),
        .hscaling_i     (dgt_hscaling_i),
        .energy_valid_o (energy_valid),
        .energy_ready_i (energy_ready),
        .energy_o       (energy_rsp)
    );

    flip_manager u_flip_manager (
        .clk_i                      (clk_i),
        .rst_i                      (rst_i),
        .config_valid_i             (config_valid_fm_i),
        .config_spin_i              (config_spin_initial_i),
        .cmpt_en_i                  (cmpt_en_i),
        .en_comparison_i            (en_comparison_i),
        .cmpt_idle_o                (cmpt_idle_o),
        .flip_ren_o                 (flip_ren_o),
        .flip_raddr_o               (flip_raddr_o),
        .icon_last_raddr_plus_one_i (icon_last_raddr_plus_one_i),
        .flip_rdata_i               (flip_rdata_i),
        .spin_valid_o               (spin_valid),
        .spin_ready_i               (spin_ready),
        .spin_o                     (spin_req),
        .energy_valid_i             (energy_valid),
        .energy_ready_o             (energy_ready),
        .energy_i                   (energy_rsp),
        .energy_fifo_update_o       (energy_fifo_update_o),
        .spin_fifo_update_o         (spin_fifo_update_o),
        .energy_fifo_o              (energy_fifo_o),
        .spin_fifo_o                (spin_fifo_o)
    );

endmodule

// ==== flip_manager/flip_manager.sv ====
module flip_manager import ising_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // initial spin
    input  logic                   config_valid_i,
    input  spin_t                  config_spin_i,
    // run control
    input  logic                   cmpt_en_i,
    input  logic                   en_comparison_i,
    output logic                   cmpt_idle_o,
    // flip-icon memory
    output logic                   flip_ren_o,
    output logic [FLIP_ADDR_W-1:0] flip_raddr_o,
    input  logic [FLIP_ADDR_W-1:0] icon_last_raddr_plus_one_i,
    input  spin_t                  flip_rdata_i,
    // candidate to the energy monitor
    output logic                   spin_valid_o,
    input  logic                   spin_ready_i,
    output spin_req_t              spin_o,
    // energy back from the monitor
    input  logic                   energy_valid_i,
    output logic                   energy_ready_o,
    input  energy_rsp_t            energy_i,
    // accepted history
    output logic                   energy_fifo_update_o,
    output logic                   spin_fifo_update_o,
    output energy_hist_t           energy_fifo_o,
    output spin_hist_t             spin_fifo_o
);
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_READ,
        ST_MASK,
        ST_ISSUE,
        ST_WAIT,
        ST_DECIDE
    } state_e;

    state_e                 state_q;
    logic                   cmpt_en_q;
    logic                   start;
    spin_t                  init_spin_q;
    spin_t                  cur_spin_q;
    logic [FLIP_ADDR_W-1:0] addr_q;
    logic                   first_q;
    logic                   update_q;
    energy_hist_t           hist_e_q;
    spin_hist_t             hist_s_q;

    spin_req_t              cand_q;
    energy_rsp_t            rsp_q;

    logic                   accept;
    logic                   last_entry;

    assign start = cmpt_en_i & ~cmpt_en_q;

    // first candidate of a run is taken without comparison
    assign accept = first_q | ~en_comparison_i |
                    ($signed(rsp_q.energy) < $signed(hist_e_q[0]));
    assign last_entry = addr_q == icon_last_raddr_plus_one_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= ST_IDLE;
            cmpt_en_q   <= 1'b0;
            init_spin_q <= '0;
            cur_spin_q  <= '0;
            addr_q      <= '0;
            first_q     <= 1'b0;
            update_q    <= 1'b0;
            hist_e_q    <= '0;
            hist_s_q    <= '0;
        end else begin
            cmpt_en_q <= cmpt_en_i;
            update_q  <= 1'b0;
            if (config_valid_i) begin
                init_spin_q <= config_spin_i;
            end
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_START;
                    end
                end
                ST_START: begin
                    addr_q  <= '0;
                    first_q <= 1'b1;
                    state_q <= ST_ISSUE;
                end
                ST_READ: begin
                    state_q <= ST_MASK;
                end
                ST_MASK: begin
                    addr_q  <= addr_q + 1'b1;
                    state_q <= ST_ISSUE;
                end
                ST_ISSUE: begin
                    if (spin_ready_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (energy_valid_i) begin
                        state_q <= ST_DECIDE;
                    end
                end
                ST_DECIDE: begin
                    if (accept) begin
                        for (int i = SPIN_DEPTH - 1; i > 0; i--) begin
                            hist_e_q[i] <= hist_e_q[i-1];
                            hist_s_q[i] <= hist_s_q[i-1];
                        end
                        hist_e_q[0] <= rsp_q.energy;
                        hist_s_q[0] <= rsp_q.spin;
                        cur_spin_q  <= rsp_q.spin;
                        update_q    <= 1'b1;
                    end
                    first_q <= 1'b0;
                    state_q <= last_entry ? ST_IDLE : ST_READ;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // candidate and returned energy
    always_ff @(posedge clk_i) begin
        if (state_q == ST_START) begin
            cand_q.spin <= init_spin_q;
        end else if (state_q == ST_MASK) begin
            cand_q.spin <= cur_spin_q ^ flip_rdata_i;
        end
        if (state_q == ST_WAIT && energy_valid_i) begin
            rsp_q <= energy_i;
        end
    end

    assign cmpt_idle_o          = state_q == ST_IDLE;
    assign flip_ren_o           = state_q == ST_READ;
    assign flip_raddr_o         = addr_q;
    assign spin_valid_o         = state_q == ST_ISSUE;
    assign spin_o               = cand_q;
    assign energy_ready_o       = state_q == ST_WAIT;
    assign energy_fifo_update_o = update_q;
    assign spin_fifo_update_o   = update_q;
    assign energy_fifo_o        = hist_e_q;
    assign spin_fifo_o          = hist_s_q;

endmodule

// ==== energy_monitor/energy_monitor.sv ====
module energy_monitor import ising_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // candidate spin in
    input  logic                   spin_valid_i,
    output logic                   spin_ready_o,
    input  spin_req_t              spin_i,
    // J row beats
    input  logic                   beat_valid_i,
    output logic                   beat_ready_o,
    input  j_beat_t                beat_i,
    input  hbias_t                 hbias_i,
    input  logic [SCALING_BIT-1:0] hscaling_i,
    // energy out
    output logic                   energy_valid_o,
    input  logic                   energy_ready_i,
    output energy_rsp_t            energy_o
);
    logic                  busy_q;
    logic [J_ADDR_W-1:0]   cnt_q;
    logic                  rsp_valid_q;

    spin_req_t             spin_q;
    energy_t               acc_q;
    energy_rsp_t           rsp_q;

    logic [SPIN_IDX_W-1:0] row_base;
    energy_t               beat_sum;
    logic                  spin_hs;
    logic                  beat_hs;
    logic                  last_beat;

    // signed contribution s_i * (sum_j J_ij*s_j + scale*h_i) of one row
    function automatic energy_t row_energy(
        input j_row_t                  row,
        input spin_t                   s,
        input logic signed [BITJ-1:0]  h,
        input logic [SCALING_BIT-1:0]  scale,
        input logic                    s_i
    );
        energy_t local_f;
        local_f = $signed(h) * $signed({1'b0, scale});
        for (int j = 0; j < NUM_SPIN; j++) begin
            if (s[j]) begin
                local_f = local_f + $signed(row[j]);
            end else begin
                local_f = local_f - $signed(row[j]);
            end
        end
        return s_i ? local_f : -local_f;
    endfunction

    assign spin_ready_o   = ~busy_q & ~rsp_valid_q;
    assign beat_ready_o   = busy_q;
    assign energy_valid_o = rsp_valid_q;
    assign energy_o       = rsp_q;

    assign spin_hs   = spin_valid_i & spin_ready_o;
    assign beat_hs   = beat_valid_i & busy_q;
    assign last_beat = cnt_q == J_ADDR_W'(NUM_READS - 1);

    // the beat counter also picks the hbias slice
    assign row_base = SPIN_IDX_W'(int'(cnt_q) * PARALLELISM);

    always_comb begin
        beat_sum = '0;
        for (int k = 0; k < PARALLELISM; k++) begin
            beat_sum = beat_sum + row_energy(beat_i[k], spin_q.spin,
                                             hbias_i[row_base + k], hscaling_i,
                                             spin_q.spin[row_base + k]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q      <= 1'b0;
            cnt_q       <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            if (spin_hs) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end
            if (beat_hs) begin
                if (last_beat) begin
                    busy_q      <= 1'b0;
                    cnt_q       <= '0;
                    rsp_valid_q <= 1'b1;
                end else begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
            if (rsp_valid_q && energy_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_hs) begin
            spin_q <= spin_i;
            acc_q  <= '0;
        end
        if (beat_hs) begin
            acc_q <= acc_q + beat_sum;
            if (last_beat) begin
                rsp_q.energy <= acc_q + beat_sum;
                rsp_q.spin   <= spin_q.spin;
            end
        end
    end

endmodule

// ==== energy_monitor/weight_fetch.sv ====
module weight_fetch import ising_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_i,
    // J memory read port
    output logic                mem_ren_o,
    output logic [J_ADDR_W-1:0] mem_raddr_o,
    input  j_beat_t             mem_rdata_i,
    // beat stream
    output logic                beat_valid_o,
    input  logic                beat_ready_i,
    output j_beat_t             beat_o
);
    logic [J_ADDR_W-1:0]    raddr_q;
    logic                   ren_q;
    logic                   ren_d;
    logic                   rvalid_q;

    // slots claimed by issued reads and released by pops
    logic [FETCH_CNT_W-1:0] claim_q;
    logic [FETCH_CNT_W-1:0] claim_after_pop;
    logic [FETCH_CNT_W-1:0] used_q;

    logic [FETCH_PTR_W-1:0] wr_ptr_q;
    logic [FETCH_PTR_W-1:0] rd_ptr_q;
    j_beat_t                fifo_q [FETCH_DEPTH];
    logic                   pop;

    assign pop             = beat_valid_o & beat_ready_i;
    assign claim_after_pop = claim_q - FETCH_CNT_W'(pop);
    assign ren_d           = claim_after_pop < FETCH_CNT_W'(FETCH_DEPTH);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ren_q    <= 1'b0;
            rvalid_q <= 1'b0;
            raddr_q  <= '0;
            claim_q  <= '0;
            used_q   <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            ren_q    <= ren_d;
            // data comes back one cycle after the strobe
            rvalid_q <= ren_q;
            claim_q  <= claim_after_pop + FETCH_CNT_W'(ren_d);
            used_q   <= used_q + FETCH_CNT_W'(rvalid_q) - FETCH_CNT_W'(pop);
            if (ren_q) begin
                if (raddr_q == J_ADDR_W'(NUM_READS - 1)) begin
                    raddr_q <= '0;
                end else begin
                    raddr_q <= raddr_q + 1'b1;
                end
            end
            if (rvalid_q) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rvalid_q) begin
            fifo_q[wr_ptr_q] <= mem_rdata_i;
        end
    end

    assign mem_ren_o    = ren_q;
    assign mem_raddr_o  = raddr_q;
    assign beat_valid_o = used_q != '0;
    assign beat_o       = fifo_q[rd_ptr_q];

endmodule

// ==== common/ising_pkg.sv ====
package ising_pkg;

    // array size
    localparam int NUM_SPIN = 16;
    localparam int SPIN_IDX_W = $clog2(NUM_SPIN);

    // signed coupling / bias entry width
    localparam int BITJ = 4;

    // unsigned h scaling width
    localparam int SCALING_BIT = 4;

    // J rows returned by one memory read
    localparam int PARALLELISM = 4;
    localparam int NUM_READS = NUM_SPIN / PARALLELISM;
    localparam int J_ADDR_W = $clog2(NUM_READS);

    localparam int ENERGY_W = 32;

    // accepted entries kept in the history
    localparam int SPIN_DEPTH = 2;

    // flip-icon address is one bit wider than the icon depth needs
    localparam int FLIP_ADDR_W = 5;

    // weight prefetch FIFO depth must stay a power of two
    localparam int FETCH_DEPTH = 2;
    localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);
    localparam int FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);

    // 1 -> +1, 0 -> -1
    typedef logic [NUM_SPIN-1:0] spin_t;

    typedef logic signed [ENERGY_W-1:0] energy_t;

    // entry j of a row sits at bits j*BITJ
    typedef logic [NUM_SPIN-1:0][BITJ-1:0] j_row_t;

    // row k of read a is spin row a*PARALLELISM+k
    typedef j_row_t [PARALLELISM-1:0] j_beat_t;

    typedef logic [NUM_SPIN-1:0][BITJ-1:0] hbias_t;

    typedef struct packed {
        spin_t spin;
    } spin_req_t;

    typedef struct packed {
        energy_t energy;
        spin_t   spin;
    } energy_rsp_t;

    // entry 0 is the newest
    typedef energy_t [SPIN_DEPTH-1:0] energy_hist_t;
    typedef spin_t [SPIN_DEPTH-1:0] spin_hist_t;

endpackage
